// File: burst_requester.sv
//********************
// Burst requester
// Splits a frame into incrementing read bursts
//********************
`timescale 1ns/1ps
`default_nettype none

module burst_requester #(
	parameter int ADDR_WIDTH = 32,
	parameter int MAX_BURST  = 16   // At most 256, the reach of len_t
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [ADDR_WIDTH-1:0] base_addr,
	input  vid_pkg::dim_t         frame_width,
	input  vid_pkg::dim_t         frame_height,
	input  logic                  ar_ready,
	output logic                  ar_valid,
	output logic [ADDR_WIDTH-1:0] ar_addr,
	output mem_rd_pkg::len_t      ar_len,
	output logic                  active
);

	vid_pkg::pix_count_t remaining;   // Pixels not yet requested
	vid_pkg::pix_count_t burst_beats;
	logic                ar_fire;

	// Full burst, or whatever is left at the end of the frame
	always_comb begin
		if (remaining > vid_pkg::pix_count_t'(MAX_BURST)) begin
			burst_beats = vid_pkg::pix_count_t'(MAX_BURST);
		end else begin
			burst_beats = remaining;
		end
	end

	assign active   = (remaining != '0);
	assign ar_valid = active;           // Held high until the last burst is taken
	assign ar_len   = mem_rd_pkg::len_t'(burst_beats - 1'b1);
	assign ar_fire  = ar_valid && ar_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			remaining <= '0;
		end else if (start) begin
			remaining <= vid_pkg::pix_count_t'(frame_width) *
				vid_pkg::pix_count_t'(frame_height);
		end else if (ar_fire) begin
			remaining <= remaining - burst_beats;
		end
	end

	// Address advances past the beats of the burst just accepted
	always_ff @(posedge clk) begin
		if (start) begin
			ar_addr <= base_addr;
		end else if (ar_fire) begin
			ar_addr <= ar_addr + ADDR_WIDTH'(burst_beats * mem_rd_pkg::BEAT_BYTES);
		end
	end

endmodule

`default_nettype wire

// File: frame_input.txt
# name width height base sink_stall mem_stall beats sum
# base and sum in hex, stall modes 0 for none and 1 for random
small_plain    8  4 00010000 0 0  32 4b6007c0
one_line      16  1 5a5a0100 0 0  16 000011e0
odd_burst      7  5 5a5a0040 0 0  35 0000120c
single_pixel   1  1 12340008 0 0   1 486e0008
sink_stall    10  6 5a5a2000 1 0  60 00079ba8
mem_stall      7  5 5a5a0040 0 1  35 0000120c
both_stall    33  3 5a5a0400 1 1  99 0001d7cc
high_xor      20  4 a5a50000 0 0  80 ffb03160
wide_line     48  2 00000000 0 1  96 e1c04740
tall_stall     3 40 5a5a8000 1 1 120 003c6f90

// File: frame_reader_top.sv
//********************
// Frame reader top level
// Requester, pixel FIFO and stream framer
//********************
`timescale 1ns/1ps
`default_nettype none

module frame_reader_top #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 32,
	parameter int MAX_BURST  = 16,
	parameter int FIFO_DEPTH = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  frame_start,
	input  logic [ADDR_WIDTH-1:0] base_addr,
	input  vid_pkg::dim_t         frame_width,
	input  vid_pkg::dim_t         frame_height,
	output logic                  busy,
	output logic                  ar_valid,
	output logic [ADDR_WIDTH-1:0] ar_addr,
	output mem_rd_pkg::len_t      ar_len,
	input  logic                  ar_ready,
	input  logic                  r_valid,
	input  logic [DATA_WIDTH-1:0] r_data,
	input  logic                  r_last,
	output logic                  r_ready,
	output logic [DATA_WIDTH-1:0] m_tdata,
	output logic                  m_tvalid,
	output logic                  m_tlast,
	output logic                  m_tuser,
	input  logic                  m_tready
);

	logic                  start_acc;
	logic                  req_active;
	logic                  out_active;
	logic                  fifo_valid;
	logic                  fifo_ready;
	logic [DATA_WIDTH-1:0] fifo_data;

	assign busy = req_active || out_active;

	// New frame only while idle
	assign start_acc = frame_start && !busy;

	burst_requester #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.MAX_BURST  (MAX_BURST)
	) u_burst_requester (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start_acc),
		.base_addr    (base_addr),
		.frame_width  (frame_width),
		.frame_height (frame_height),
		.ar_ready     (ar_ready),
		.ar_valid     (ar_valid),
		.ar_addr      (ar_addr),
		.ar_len       (ar_len),
		.active       (req_active)
	);

	pixel_fifo #(
		.WIDTH (DATA_WIDTH),
		.DEPTH (FIFO_DEPTH)
	) u_pixel_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (r_valid),
		.in_data   (r_data),
		.out_ready (fifo_ready),
		.in_ready  (r_ready),    // Memory stalls when the FIFO fills
		.out_valid (fifo_valid),
		.out_data  (fifo_data)
	);

	memory_reader_output #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_memory_reader_output (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start_acc),
		.frame_width  (frame_width),
		.frame_height (frame_height),
		.pix_valid    (fifo_valid),
		.pix_data     (fifo_data),
		.m_tready     (m_tready),
		.pix_ready    (fifo_ready),
		.m_tdata      (m_tdata),
		.m_tvalid     (m_tvalid),
		.m_tlast      (m_tlast),
		.m_tuser      (m_tuser),
		.active       (out_active)
	);

endmodule

`default_nettype wire

// File: mem_rd_pkg.sv
//********************
// Memory read protocol types and fixed codes
//********************
`default_nettype none

package mem_rd_pkg;

	// Burst length, beats minus one
	typedef logic [7:0] len_t;

	localparam int unsigned BEAT_BYTES = 4; // Address step per beat

	// Fixed beat size and burst type, never driven on a port
	localparam logic [2:0] SIZE_4B    = 3'b010;
	localparam logic [1:0] BURST_INCR = 2'b01;

endpackage

`default_nettype wire

// File: memory_reader_output.sv
//********************
// Stream framer
// Pops pixels and marks start of frame and end of line
//********************
`timescale 1ns/1ps
`default_nettype none

module memory_reader_output #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  vid_pkg::dim_t         frame_width,
	input  vid_pkg::dim_t         frame_height,
	input  logic                  pix_valid,
	input  logic [DATA_WIDTH-1:0] pix_data,
	input  logic                  m_tready,
	output logic                  pix_ready,
	output logic [DATA_WIDTH-1:0] m_tdata,
	output logic                  m_tvalid,
	output logic                  m_tlast,
	output logic                  m_tuser,
	output logic                  active
);

	typedef enum logic {
		ST_IDLE,
		ST_STREAM
	} state_t;

	state_t        state;
	vid_pkg::dim_t width_q;
	vid_pkg::dim_t height_q;
	vid_pkg::dim_t col;
	vid_pkg::dim_t line;
	logic          last_col;
	logic          last_line;
	logic          xfer;

	assign active    = (state == ST_STREAM);
	assign last_col  = (col == width_q - 1'b1);
	assign last_line = (line == height_q - 1'b1);

	// Pop and stream transfer are one event
	assign pix_ready = active && m_tready;
	assign m_tvalid  = active && pix_valid;
	assign m_tdata   = pix_data;   // FIFO head holds still until popped
	assign m_tlast   = active && last_col;
	assign m_tuser   = active && (col == '0) && (line == '0);
	assign xfer      = m_tvalid && m_tready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			col   <= '0;
			line  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_STREAM;
						col   <= '0;
						line  <= '0;
					end
				end
				ST_STREAM: begin
					if (xfer) begin
						if (last_col) begin
							col <= '0;
							if (last_line) state <= ST_IDLE;   // Frame done
							else line <= line + 1'b1;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Geometry held for the whole frame
	always_ff @(posedge clk) begin
		if (start && (state == ST_IDLE)) begin
			width_q  <= frame_width;
			height_q <= frame_height;
		end
	end

endmodule

`default_nettype wire

// File: pixel_fifo.sv
//********************
// Synchronous FIFO for returned read data
//********************
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 32    // Power of two
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [WIDTH-1:0] in_data,
	input  logic             out_ready,
	output logic             in_ready,
	output logic             out_valid,
	output logic [WIDTH-1:0] out_data
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             ready_en;   // Low until the first cycle out of reset
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full      = (count == (PTR_W+1)'(DEPTH));
	// A pop in the same cycle frees the slot for a push when full
	assign in_ready  = ready_en && (!full || out_ready);
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];
	assign do_wr     = in_valid && in_ready;
	assign do_rd     = out_valid && out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_en <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
		end else begin
			ready_en <= 1'b1;
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule

`default_nettype wire

// File: sources.f
vid_pkg.sv
mem_rd_pkg.sv
burst_requester.sv
pixel_fifo.sv
memory_reader_output.sv
frame_reader_top.sv
tb_stream_checker.sv
tb_frame_reader.sv

// File: tb_frame_reader.sv
//********************
// Frame reader testbench
// File-driven tests, memory responder, timeout
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_frame_reader;

	localparam int MAX_TESTS = 16;
	localparam int MAX_BURST = 16;

	logic             clk = 1'b0;
	logic             rst_n;
	logic             frame_start;
	logic             busy;
	logic [31:0]      base_addr;
	vid_pkg::dim_t    frame_width;
	vid_pkg::dim_t    frame_height;
	logic             ar_valid, ar_ready, r_valid, r_last, r_ready;
	logic [31:0]      ar_addr;
	mem_rd_pkg::len_t ar_len;
	logic [31:0]      r_data;
	logic [31:0]      m_tdata;
	logic             m_tvalid, m_tlast, m_tuser, m_tready;

	// Test table from frame_input.txt
	logic [8*24-1:0]  names [MAX_TESTS];
	logic [31:0]      bases [MAX_TESTS];
	logic [31:0]      sums [MAX_TESTS];
	int               widths [MAX_TESTS];
	int               heights [MAX_TESTS];
	int               sink_modes [MAX_TESTS];
	int               mem_modes [MAX_TESTS];
	int               beat_counts [MAX_TESTS];
	int               ntests, limit, file_errors, stim_errors, mem_errors;
	int               pass_count, fail_count, sink_mode, mem_mode;
	int               cycles = 0;
	logic [8*24-1:0]  cur_name;
	logic [31:0]      cur_base, cur_sum;
	int               cur_beats;

	// Memory responder state
	logic [31:0]      burst_addr [$];
	mem_rd_pkg::len_t burst_len [$];
	logic [31:0]      next_addr;
	logic [31:0]      rnd;
	int               beat;
	int               pix_left;   // Pixels of the frame not yet requested

	always #50 clk = ~clk;

	frame_reader_top #(
		.DATA_WIDTH (32), .ADDR_WIDTH (32), .MAX_BURST (MAX_BURST), .FIFO_DEPTH (32)
	) u_frame_reader_top (
		.clk (clk), .rst_n (rst_n), .frame_start (frame_start), .base_addr (base_addr),
		.frame_width (frame_width), .frame_height (frame_height), .busy (busy),
		.ar_valid (ar_valid), .ar_addr (ar_addr), .ar_len (ar_len), .ar_ready (ar_ready),
		.r_valid (r_valid), .r_data (r_data), .r_last (r_last), .r_ready (r_ready),
		.m_tdata (m_tdata), .m_tvalid (m_tvalid), .m_tlast (m_tlast), .m_tuser (m_tuser),
		.m_tready (m_tready)
	);

	tb_stream_checker u_checker (
		.clk (clk), .rst_n (rst_n), .busy (busy), .m_tdata (m_tdata), .m_tvalid (m_tvalid),
		.m_tlast (m_tlast), .m_tuser (m_tuser), .m_tready (m_tready), .test_name (cur_name),
		.exp_base (cur_base), .exp_width (frame_width), .exp_height (frame_height),
		.exp_beats (cur_beats), .exp_sum (cur_sum), .mem_errors (mem_errors),
		.pass_count (pass_count), .fail_count (fail_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_tests();
		int               fd, n, w, h, sm, mm, nb;
		logic [31:0]      b, s;
		logic [8*24-1:0]  nm;
		logic [8*128-1:0] text;
		ntests = 0;
		limit  = 200;
		fd = $fopen("frame_input.txt", "r");
		if (fd == 0) begin
			file_errors++;
			$display("cannot open frame_input.txt");
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(text, fd) != 0) begin
					n = $sscanf(text, "%s %d %d %h %d %d %d %h", nm, w, h, b, sm, mm, nb, s);
					if (n == 8) begin   // Comment lines scan short
						if (w < 1 || h < 1 ||
								w > vid_pkg::MAX_WIDTH || h > vid_pkg::MAX_HEIGHT) begin
							file_errors++;
							$display("entry %0s has a frame size outside the limits", nm);
						end else if (ntests < MAX_TESTS) begin
							names[ntests]       = nm;
							widths[ntests]      = w;
							heights[ntests]     = h;
							bases[ntests]       = b;
							sink_modes[ntests]  = sm;
							mem_modes[ntests]   = mm;
							beat_counts[ntests] = nb;
							sums[ntests]        = s;
							limit  = limit + w * h * 8;
							ntests++;
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int t);
		@(posedge clk);
		#5;
		cur_name     = names[t];
		cur_base     = bases[t];
		cur_beats    = beat_counts[t];
		cur_sum      = sums[t];
		sink_mode    = sink_modes[t];
		mem_mode     = mem_modes[t];
		base_addr    = bases[t];
		frame_width  = vid_pkg::dim_t'(widths[t]);
		frame_height = vid_pkg::dim_t'(heights[t]);
		frame_start  = 1'b1;
		@(posedge clk);
		#5;
		frame_start = 1'b0;
		if (!busy) begin
			stim_errors++;
			$display("frame start for %0s was not accepted", cur_name);
		end else begin
			// Repeat start with another base while the frame runs, must be ignored
			base_addr   = bases[t] + 32'h1000;
			frame_start = 1'b1;
			@(posedge clk);
			#5;
			frame_start = 1'b0;
			base_addr   = bases[t];
			while (busy) begin
				@(posedge clk);
				#5;
			end
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		frame_start  = 1'b0;
		base_addr    = '0;
		frame_width  = '0;
		frame_height = '0;
		sink_mode    = 0;
		mem_mode     = 0;
		cur_name     = '0;
		cur_base     = '0;
		cur_sum      = '0;
		cur_beats    = 0;
		file_errors  = 0;
		stim_errors  = 0;
		load_tests();
		if (ntests == 0) begin
			$display("no usable test found in frame_input.txt");
			$display("Test failed");
			$finish;
		end else begin
			repeat (4) @(posedge clk);
			#5;
			rst_n = 1'b1;
			for (int t = 0; t < ntests; t++) run_test(t);
			repeat (2) @(posedge clk);
			$display("tests: %0d passed, %0d failed", pass_count, fail_count);
			if (pass_count == ntests && fail_count == 0 && file_errors == 0 &&
					stim_errors == 0 && mem_errors == 0) begin
				$display("Test completed successfully");
			end else begin
				if (pass_count + fail_count != ntests)
					$display("only %0d of %0d frames were completed",
						pass_count + fail_count, ntests);
				$display("Test failed");
			end
			$finish;
		end
	end

	// In-order memory, word at byte address A is A ^ 32'h5a5a0000
	initial begin : responder
		logic fired;
		logic bad_req;
		int   smode;
		int   mmode;
		int   exp_len;
		ar_ready   = 1'b0;
		r_valid    = 1'b0;
		r_data     = '0;
		r_last     = 1'b0;
		m_tready   = 1'b0;
		mem_errors = 0;
		beat       = 0;
		next_addr  = '0;
		pix_left   = 0;
		rnd        = 32'h6ce0;
		// Only 4-byte beats in incrementing bursts are modeled
		if ((1 << mem_rd_pkg::SIZE_4B) != mem_rd_pkg::BEAT_BYTES ||
				mem_rd_pkg::BURST_INCR != 2'b01) begin
			mem_errors++;
			$display("memory model does not match the burst size or type codes");
		end
		forever begin
			@(posedge clk);
			fired   = r_valid && r_ready;
			smode   = sink_mode;
			mmode   = mem_mode;
			bad_req = 1'b0;
			if (frame_start && !busy) begin   // Accepted start
				next_addr = base_addr;
				pix_left  = int'(frame_width) * int'(frame_height);
			end
			if (ar_valid && ar_ready) begin
				// Full bursts, the remainder in the last one
				exp_len = (pix_left > MAX_BURST) ? MAX_BURST : pix_left;
				if (ar_addr !== next_addr || 32'(ar_len) + 1 != exp_len) begin
					bad_req = 1'b1;
					$display("error %0s: burst expected %0d beats at %h actual %0d beats at %h",
						cur_name, exp_len, next_addr, 32'(ar_len) + 1, ar_addr);
				end
				burst_addr.push_back(ar_addr);
				burst_len.push_back(ar_len);
				next_addr = ar_addr + (32'(ar_len) + 1) * mem_rd_pkg::BEAT_BYTES;
				pix_left  = pix_left - (32'(ar_len) + 1);
			end
			if (fired && r_last) begin
				void'(burst_addr.pop_front());
				void'(burst_len.pop_front());
				beat = 0;
			end else if (fired) begin
				beat++;
			end
			rnd = lcg_next(rnd);
			#5;
			if (bad_req) mem_errors++;
			ar_ready = (mmode == 0) || (rnd[21:20] != 2'b00);
			m_tready = (smode == 0) || (rnd[25:24] != 2'b00);
			if (!r_valid || fired) begin   // An offered beat holds until taken
				r_valid = (burst_addr.size() > 0) && ((mmode == 0) || (rnd[29:28] != 2'b00));
				if (r_valid) begin
					r_data = (burst_addr[0] + beat * mem_rd_pkg::BEAT_BYTES) ^ 32'h5a5a0000;
					r_last = (beat == 32'(burst_len[0]));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb_stream_checker.sv
//********************
// Stream checker
// Per-beat data and marks, per-frame counts and sum
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_stream_checker (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            busy,
	input  logic [31:0]     m_tdata,
	input  logic            m_tvalid,
	input  logic            m_tlast,
	input  logic            m_tuser,
	input  logic            m_tready,
	input  logic [8*24-1:0] test_name,
	input  logic [31:0]     exp_base,
	input  vid_pkg::dim_t   exp_width,
	input  vid_pkg::dim_t   exp_height,
	input  int              exp_beats,
	input  logic [31:0]     exp_sum,
	input  int              mem_errors,
	output int              pass_count,
	output int              fail_count
);

	vid_pkg::pix_count_t beat_idx;
	int                  last_count;
	int                  errs;
	int                  mem_errs_at_start;
	logic [31:0]         data_sum;
	logic                busy_q;
	logic                stalled;   // Beat offered but not taken
	logic [33:0]         held;      // tdata, tlast, tuser of that beat

	// Word stored at a byte address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return addr ^ 32'h5a5a0000;
	endfunction

	task automatic report_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		errs++;
		if (errs <= 5) $display("error %0s: %0s expected %h actual %h", test_name, what, exp, act);
	endtask

	task automatic report_count(input string what, input int exp, input int act);
		errs++;
		$display("error %0s: %0s expected %0d actual %0d", test_name, what, exp, act);
	endtask

	task automatic check_beat();
		logic [31:0] exp_data;
		logic        exp_last;
		exp_data = word_at(exp_base + beat_idx * 4);
		exp_last = (beat_idx % exp_width) == vid_pkg::pix_count_t'(exp_width) - 1;
		if (m_tdata !== exp_data)
			report_value($sformatf("data at beat %0d", beat_idx), exp_data, m_tdata);
		if (m_tuser !== (beat_idx == 0))
			report_value($sformatf("tuser at beat %0d", beat_idx), beat_idx == 0, m_tuser);
		if (m_tlast !== exp_last)
			report_value($sformatf("tlast at beat %0d", beat_idx), exp_last, m_tlast);
		if (m_tlast) last_count++;
		data_sum = data_sum + m_tdata;
		beat_idx++;
	endtask

	task automatic finish_test();
		if (beat_idx != exp_beats) report_count("beat count", exp_beats, beat_idx);
		if (last_count != exp_height) report_count("tlast count", exp_height, last_count);
		if (data_sum !== exp_sum) report_value("data sum", exp_sum, data_sum);
		if (mem_errors != mem_errs_at_start) begin
			errs++;
			$display("%0s: the memory model saw a bad burst request", test_name);
		end
		if (errs == 0) begin
			pass_count++;
			$display("test %0s passed with %0d beats", test_name, beat_idx);
		end else begin
			fail_count++;
			$display("test %0s failed with %0d errors", test_name, errs);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			pass_count = 0;
			fail_count = 0;
			busy_q     = 1'b0;
			stalled    = 1'b0;
		end else begin
			if (busy && !busy_q) begin   // Frame accepted
				beat_idx          = '0;
				last_count        = 0;
				errs              = 0;
				data_sum          = '0;
				mem_errs_at_start = mem_errors;
			end
			if (stalled && (!m_tvalid || {m_tdata, m_tlast, m_tuser} !== held)) begin
				errs++;
				$display("%0s: stream beat %0d changed before it was taken", test_name, beat_idx);
			end
			if (m_tvalid && m_tready) check_beat();
			stalled = m_tvalid && !m_tready;
			held    = {m_tdata, m_tlast, m_tuser};
			if (busy_q && !busy) finish_test();
			busy_q = busy;
		end
	end

endmodule

`default_nettype wire

// File: vid_pkg.sv
//********************
// Frame geometry types and size limits
//********************
`default_nettype none

package vid_pkg;

	// Line width or frame height in pixels
	typedef logic [15:0] dim_t;

	// Total pixels in a frame, width times height
	typedef logic [31:0] pix_count_t;

	localparam int unsigned MAX_WIDTH  = 1280;
	localparam int unsigned MAX_HEIGHT = 720;

endpackage

`default_nettype wire
